/* source/dedekindPkg.sv */
package dedekindPkg;

    // function geometry
    localparam int funcBits  = 128;          // truth table of a 7 variable function
    localparam int halfBits  = funcBits / 2; // one bot input line
    localparam int numPerms  = 6;            // orderings of A, B, C
    localparam int popBits   = $clog2(funcBits + 1); // popcount 0..128

    // result word fields
    localparam int indexBits = 23; // bot sequence number
    localparam int countBits = 3;  // pcoeffCount, 0..6
    localparam int sumBits   = 38; // summedData

    // result buffer
    localparam int fifoDepth    = 32;
    localparam int fifoAddrBits = $clog2(fifoDepth);
    localparam int inFlight     = 4;                         // regs between intake and fifo write
    localparam int slowLevel    = fifoDepth - inFlight - 1;  // stop intake at this fill

    // source index bit for the new A, B and C slot, one row per permValid bit
    // row 5 is ABC (identity), row 0 is CBA
    localparam int permSrc [numPerms][3] = '{
        '{6, 5, 4}, // CBA
        '{6, 4, 5}, // CAB
        '{5, 6, 4}, // BCA
        '{5, 4, 6}, // BAC
        '{4, 6, 5}, // ACB
        '{4, 5, 6}  // ABC
    };

    // stage 1 -> stage 2
    typedef struct packed {
        logic                 valid;
        logic [indexBits-1:0] index; // number since last new top
        logic [funcBits-1:0]  top;   // top in force when the bot was taken
        logic [funcBits-1:0]  bot;
    } botItemT;

    // stage 2 -> stage 3
    typedef struct packed {
        logic                 valid;
        logic [indexBits-1:0] index;
        logic [funcBits-1:0]  top;
        logic [funcBits-1:0]  bot;
        logic [numPerms-1:0]  permValid; // ABC ACB BAC BCA CAB CBA, msb first
    } checkItemT;

    // 64 bit result word
    typedef struct packed {
        logic [indexBits-1:0] index;       // 63:41
        logic [countBits-1:0] pcoeffCount; // 40:38
        logic [sumBits-1:0]   summedData;  // 37:0
    } resultT;

endpackage

/* source/botIntake.sv */
`timescale 1ns/1ns

module botIntake import dedekindPkg::*; (
    input  logic                clock,
    input  logic                rstLocal,
    input  logic                ivalid,
    input  logic                startNewTop,
    input  logic [funcBits-1:0] bot,           // also carries top on startNewTop
    input  logic                slowInputting, // fifo near full
    output logic                oready,
    output botItemT             botItem
);

    logic [funcBits-1:0]  top;      // current top
    logic [indexBits-1:0] seqIndex; // next bot number
    logic                 accept;

    // host may only push while we are not throttled
    assign oready = !slowInputting;

    // a new top cycle never counts as a bot
    assign accept = ivalid && !slowInputting && !startNewTop;

    // payload capture
    always_ff @(posedge clock) begin
        if (accept) begin
            botItem.index <= seqIndex; // number it
            botItem.top   <= top;      // top travels with the bot
            botItem.bot   <= bot;
        end
    end

    // top register, counter and stage valid
    always_ff @(posedge clock) begin
        if (rstLocal) begin
            top           <= '0;
            seqIndex      <= '0;
            botItem.valid <= 1'b0;
        end else begin
            botItem.valid <= accept;
            if (startNewTop) begin
                top      <= bot; // reuse bot lines for top
                seqIndex <= '0;  // numbering restarts per top
            end else if (accept) begin
                seqIndex <= seqIndex + 1'b1;
            end
        end
    end

    // Older bots already hold their own copy of top, so loading a new one
    // here does not disturb anything still in the pipeline.

endmodule

/* source/permuteCheck6.sv */
`timescale 1ns/1ns

module permuteCheck6 import dedekindPkg::*; (
    input  logic      clock,
    input  logic      rstLocal,
    input  botItemT   botItem,
    output checkItemT checkItem
);

    logic [funcBits-1:0] permBot [numPerms]; // bot with A/B/C reordered
    logic [numPerms-1:0] fits;               // permuted bot inside top

    // reorder index bits 4..6 of a truth table
    // new slot A reads old bit srcA and likewise for B and C
    // bits 3..0 pass unchanged
    function automatic logic [funcBits-1:0] permuteVars(
        input logic [funcBits-1:0] f,
        input int                  srcA,
        input int                  srcB,
        input int                  srcC
    );
        logic [funcBits-1:0] res;
        logic [6:0]          idx;
        logic [6:0]          src;
        res = '0;
        for (int i = 0; i < funcBits; i++) begin
            idx    = 7'(i);
            src    = {idx[srcC], idx[srcB], idx[srcA], idx[3:0]};
            res[i] = f[src];
        end
        return res;
    endfunction

    for (genvar k = 0; k < numPerms; k++) begin : gPerm
        assign permBot[k] = permuteVars(botItem.bot, permSrc[k][0], permSrc[k][1],
                                        permSrc[k][2]);
        assign fits[k]    = ~|(permBot[k] & ~botItem.top); // no bit outside top
    end

    // pass-through fields and mask
    always_ff @(posedge clock) begin
        checkItem.index     <= botItem.index;
        checkItem.top       <= botItem.top;
        checkItem.bot       <= botItem.bot;
        checkItem.permValid <= botItem.valid ? fits : '0; // bubbles carry no hits
    end

    always_ff @(posedge clock) begin
        if (rstLocal) begin
            checkItem.valid <= 1'b0;
        end else begin
            checkItem.valid <= botItem.valid;
        end
    end

endmodule

/* source/coeffAccumulate.sv */
`timescale 1ns/1ns

module coeffAccumulate import dedekindPkg::*; (
    input  logic      clock,
    input  logic      rstLocal,
    input  checkItemT checkItem,
    output resultT    result,
    output logic      resultValid
);

    // first register
    logic                 validA;
    logic [indexBits-1:0] indexA;
    logic [popBits-1:0]   topCountA; // ones in top
    logic [popBits-1:0]   botCountA; // ones in bot
    logic [countBits-1:0] permCountA; // fitting permutations

    // second stage math
    logic [popBits-1:0] popDiff;
    logic [sumBits-1:0] summed;

    always_ff @(posedge clock) begin
        indexA     <= checkItem.index;
        topCountA  <= popBits'($countones(checkItem.top));
        botCountA  <= popBits'($countones(checkItem.bot));
        permCountA <= countBits'($countones(checkItem.permValid));
    end

    // Any fitting permutation keeps the popcount of bot, so bot <= top whenever
    // permCountA is nonzero. With no fit the wrapped difference is multiplied
    // by zero and drops out.
    assign popDiff = topCountA - botCountA;
    assign summed  = sumBits'(permCountA) * sumBits'(popDiff);

    always_ff @(posedge clock) begin
        result.index       <= indexA;
        result.pcoeffCount <= permCountA;
        result.summedData  <= summed; // uncovered top bits over all fits
    end

    // valid chain through both registers
    always_ff @(posedge clock) begin
        if (rstLocal) begin
            validA      <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            validA      <= checkItem.valid;
            resultValid <= validA;
        end
    end

endmodule

/* source/outputBuffer.sv */
`timescale 1ns/1ns

module outputBuffer import dedekindPkg::*; (
    input  logic   clock,
    input  logic   rstLocal,
    input  logic   resultValid,   // write strobe from the pipeline
    input  resultT result,
    input  logic   iready,        // host takes dataOut
    output logic   slowInputting, // throttle intake
    output logic   ovalid,
    output resultT dataOut
);

    resultT                  mem [fifoDepth]; // circular store
    logic [fifoAddrBits-1:0] wrPtr;
    logic [fifoAddrBits-1:0] rdPtr;
    logic [fifoAddrBits:0]   count;     // words held in mem
    logic [fifoAddrBits:0]   countNext;
    logic                    doRead;    // move head into dataOut

    // refill the output word when it is empty or being taken
    assign doRead = (count != '0) && (!ovalid || iready);

    always_comb begin
        countNext = count + (fifoAddrBits + 1)'(resultValid)
                          - (fifoAddrBits + 1)'(doRead);
    end

    // circular storage
    always_ff @(posedge clock) begin
        if (resultValid) begin
            mem[wrPtr] <= result;
        end
    end

    // registered read word
    always_ff @(posedge clock) begin
        if (doRead) begin
            dataOut <= mem[rdPtr];
        end
    end

    // pointers, fill level, output valid and throttle
    always_ff @(posedge clock) begin
        if (rstLocal) begin
            wrPtr         <= '0;
            rdPtr         <= '0;
            count         <= '0;
            ovalid        <= 1'b0;
            slowInputting <= 1'b0;
        end else begin
            if (resultValid) begin
                wrPtr <= wrPtr + 1'b1; // wraps at depth
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= countNext;

            if (doRead) begin
                ovalid <= 1'b1; // fresh word presented
            end else if (iready) begin
                ovalid <= 1'b0; // taken, nothing behind it
            end

            // leaves room for everything still in the pipeline
            slowInputting <= (countNext >= slowLevel);
        end
    end

    // Worst case: fill reaches slowLevel on the same edge that takes one more
    // bot, then inFlight words still land, giving at most fifoDepth - 1.

endmodule

/* source/openCLFullPipeline.sv */
`timescale 1ns/1ns

module openCLFullPipeline import dedekindPkg::*; (
    input  logic                clock,
    input  logic                rstLocal,
    input  logic                ivalid,
    input  logic                iready,
    output logic                ovalid,
    output logic                oready,
    input  logic                startNewTop, // bot lines carry top this cycle
    input  logic [halfBits-1:0] botLower,
    input  logic [halfBits-1:0] botUpper,
    output logic [63:0]         summedDataPcoeffCountOut // index, count, sum
);

    logic [funcBits-1:0] bot;           // joined input lines
    botItemT             botItem;       // stage 1 out
    checkItemT           checkItem;     // stage 2 out
    resultT              result;        // stage 4 out
    logic                resultValid;
    logic                slowInputting; // fifo back-pressure

    assign bot = {botUpper, botLower};

    botIntake i_botIntake (
        .clock         (clock),
        .rstLocal      (rstLocal),
        .ivalid        (ivalid),
        .startNewTop   (startNewTop),
        .bot           (bot),
        .slowInputting (slowInputting),
        .oready        (oready),
        .botItem       (botItem)
    );

    permuteCheck6 i_permuteCheck6 (
        .clock     (clock),
        .rstLocal  (rstLocal),
        .botItem   (botItem),
        .checkItem (checkItem)
    );

    coeffAccumulate i_coeffAccumulate (
        .clock       (clock),
        .rstLocal    (rstLocal),
        .checkItem   (checkItem),
        .result      (result),
        .resultValid (resultValid)
    );

    outputBuffer i_outputBuffer (
        .clock         (clock),
        .rstLocal      (rstLocal),
        .resultValid   (resultValid),
        .result        (result),
        .iready        (iready),
        .slowInputting (slowInputting),
        .ovalid        (ovalid),
        .dataOut       (summedDataPcoeffCountOut) // 64 bit resultT
    );

endmodule

/* testbench/openCLFullPipelineTb.sv */
`timescale 1ns/1ns

module openCLFullPipelineTb import dedekindPkg::*; ();

    localparam int numDirected = 15;               // tops and hand picked bots
    localparam int numRandom   = 40;               // random bots under fixedTop
    localparam int numEntries  = numDirected + numRandom;
    localparam int cycleLimit  = 20 * numEntries + 200;
    localparam int stallLen    = 60;               // cycles of iready low
    localparam int noStall     = 32'h7fff_0000;    // stall start not yet armed
    localparam int drainLimit  = 300;
    localparam logic [funcBits-1:0] topA     = 128'hffff0000_ffff0000_ffff0000_ffff0000;
    localparam logic [funcBits-1:0] topCorA  = 128'hffffffff_ffffffff_00000000_ffff0000;
    localparam logic [funcBits-1:0] fixedTop = 128'hffffffff_ffffffff_ff00ff00_ffff0000;
    // variables landing in slots A, B and C for permutation p
    localparam int permTable [6][3] = '{'{0, 1, 2}, '{0, 2, 1}, '{1, 0, 2},
                                        '{1, 2, 0}, '{2, 0, 1}, '{2, 1, 0}};

    typedef struct packed {
        logic                isTop;    // load top instead of a bot
        logic                stallOut; // starts the iready low window
        logic [funcBits-1:0] data;
        logic [63:0]         expected; // bots only
    } entryT;

    logic                clock = 1'b0;
    logic                rstLocal;
    logic                ivalid;
    logic                iready = 1'b1;
    logic                startNewTop;
    logic [halfBits-1:0] botLower;
    logic [halfBits-1:0] botUpper;
    logic                ovalid;
    logic                oready;
    logic [63:0]         summedDataPcoeffCountOut;

    entryT               stim [numEntries];
    logic [63:0]         expQ [$];              // words owed by the DUT, in order
    int                  cycles      = 0;
    int                  stallFrom   = noStall;
    int                  fillPos     = 0;
    logic [funcBits-1:0] modelTop    = '0;      // top as seen by the model
    int                  modelIndex  = 0;
    int                  seed        = 32'h32a8;
    int                  valueErrors = 0;
    int                  extraErrors = 0;
    int                  missingErrors = 0;
    int                  otherErrors = 0;
    logic                sawOreadyLow  = 1'b0;
    logic                sawOreadyRise = 1'b0;

    openCLFullPipeline i_dut (
        .clock                    (clock),
        .rstLocal                 (rstLocal),
        .ivalid                   (ivalid),
        .iready                   (iready),
        .ovalid                   (ovalid),
        .oready                   (oready),
        .startNewTop              (startNewTop),
        .botLower                 (botLower),
        .botUpper                 (botUpper),
        .summedDataPcoeffCountOut (summedDataPcoeffCountOut)
    );

    always #2 clock = ~clock; // 4 ns period

    // cycle count and the iready stall window
    always @(posedge clock) begin
        cycles <= cycles + 1;
        iready <= !(cycles >= stallFrom && cycles < stallFrom + stallLen);
    end

    // scatter each minterm so that slot j takes variable permTable[p][j]
    function automatic logic [funcBits-1:0] permuteABC(input logic [funcBits-1:0] f, input int p);
        logic [funcBits-1:0] g;
        logic [6:0]          mm;
        logic [6:0]          n;
        g = '0;
        for (int m = 0; m < funcBits; m++) begin
            mm = 7'(m);
            n  = mm;
            for (int j = 0; j < 3; j++) begin
                n[4 + j] = mm[4 + permTable[p][j]];
            end
            g[n] = f[m];
        end
        return g;
    endfunction

    function automatic int countOnes(input logic [funcBits-1:0] f);
        int cnt;
        cnt = 0;
        for (int i = 0; i < funcBits; i++) begin
            if (f[i]) cnt++;
        end
        return cnt;
    endfunction

    // count fitting permutations, weight by the uncovered top bits, attach number
    function automatic logic [63:0] expectedWord(input logic [funcBits-1:0] top,
                                                 input logic [funcBits-1:0] bot, input int idx);
        int          fitsCount;
        int          diff;
        logic [37:0] sum;
        fitsCount = 0;
        for (int p = 0; p < 6; p++) begin
            if ((permuteABC(bot, p) & ~top) == '0) fitsCount++;
        end
        diff = countOnes(top) - countOnes(bot);
        sum  = (fitsCount == 0) ? '0 : 38'(fitsCount * diff);
        return {23'(idx), 3'(fitsCount), sum};
    endfunction

    task automatic addEntry(input logic isTop, input logic [funcBits-1:0] data, input logic stall);
        stim[fillPos].isTop    = isTop;
        stim[fillPos].stallOut = stall;
        stim[fillPos].data     = data;
        stim[fillPos].expected = '0;
        if (isTop) begin
            modelTop   = data;
            modelIndex = 0; // numbering restarts
        end else begin
            stim[fillPos].expected = expectedWord(modelTop, data, modelIndex);
            modelIndex++;
        end
        fillPos++;
    endtask

    // offer one entry until taken
    task automatic applyEntry(input int e);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(posedge clock);
            startNewTop            <= stim[e].isTop;
            ivalid                 <= 1'b1;             // also high on a top cycle
            {botUpper, botLower}   <= stim[e].data;
            @(negedge clock);
            if (stim[e].stallOut && stallFrom == noStall) stallFrom = cycles + 1;
            if (stim[e].isTop) begin
                taken = 1'b1;
            end else if (oready) begin
                taken = 1'b1;                      // accepted on the coming edge
                expQ.push_back(stim[e].expected);
            end
        end
    endtask

    // output side sampled mid cycle
    always @(negedge clock) begin : monitor
        logic [63:0] want;
        if (!rstLocal && ovalid && iready) begin
            if (expQ.size() == 0) begin
                extraErrors++;
                $display("extra result word %h arrived with nothing expected",
                         summedDataPcoeffCountOut);
            end else begin
                want = expQ.pop_front();
                if (summedDataPcoeffCountOut !== want) begin
                    valueErrors++;
                    $display("FAIL summedDataPcoeffCountOut got 0x%h expected 0x%h",
                             summedDataPcoeffCountOut, want);
                end
            end
        end
        if (!rstLocal) begin
            if (!oready) sawOreadyLow = 1'b1;
            else if (sawOreadyLow) sawOreadyRise = 1'b1; // back-pressure released
        end
    end

    initial begin : watchdog
        wait (cycles >= cycleLimit);
        $display("timeout after %0d cycles with %0d results outstanding", cycles, expQ.size());
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main
        logic [funcBits-1:0] r;
        int                  waited;
        rstLocal    = 1'b1;
        ivalid      = 1'b0;
        startNewTop = 1'b0;
        botLower    = '0;
        botUpper    = '0;

        addEntry(1'b1, '1, 1'b0);                  // top all ones
        addEntry(1'b0, '0, 1'b0);
        addEntry(1'b0, 128'h1, 1'b0);
        addEntry(1'b0, 128'hf0f0_1234_0000_8001_00ff_0f0f_dead_beef, 1'b0);
        addEntry(1'b1, topA, 1'b0);                // top is variable A
        addEntry(1'b0, 128'h1 << 16, 1'b0);        // A only
        addEntry(1'b0, 128'h1 << 32, 1'b0);        // B only
        addEntry(1'b0, 128'h1 << 48, 1'b0);        // A and B
        addEntry(1'b0, 128'h1 << 64, 1'b0);        // C only
        addEntry(1'b0, 128'h1, 1'b0);              // outside top under every permutation
        addEntry(1'b1, topCorA, 1'b0);             // loaded with bots still in flight
        addEntry(1'b0, 128'h1 << 16, 1'b0);
        addEntry(1'b0, 128'h1 << 48, 1'b0);
        addEntry(1'b0, '0, 1'b0);
        addEntry(1'b1, fixedTop, 1'b0);
        for (int i = 0; i < numRandom; i++) begin
            r = {$random(seed), $random(seed), $random(seed), $random(seed)};
            addEntry(1'b0, r & fixedTop, 1'b1);
        end

        repeat (10) @(posedge clock);
        rstLocal <= 1'b0;
        @(negedge clock);
        if (ovalid !== 1'b0) begin
            otherErrors++;
            $display("FAIL ovalid got 0x%h expected 0x0", ovalid);
        end
        if (oready !== 1'b1) begin
            otherErrors++;
            $display("FAIL oready got 0x%h expected 0x1", oready);
        end

        for (int e = 0; e < numEntries; e++) begin
            applyEntry(e);
        end
        @(posedge clock);
        ivalid      <= 1'b0;
        startNewTop <= 1'b0;

        waited = 0;
        while (expQ.size() != 0 && waited < drainLimit) begin
            @(negedge clock);
            waited++;
        end
        if (expQ.size() != 0) begin
            missingErrors = expQ.size();
            $display("%0d result words never arrived", missingErrors);
        end
        repeat (20) @(negedge clock); // idle window to catch extra words
        if (!sawOreadyLow || !sawOreadyRise) begin
            otherErrors++;
            $display("oready did not drop and recover while the output was stalled");
        end

        $display("errors: value %0d, missing %0d, extra %0d, other %0d",
                 valueErrors, missingErrors, extraErrors, otherErrors);
        if (valueErrors + missingErrors + extraErrors + otherErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
source/dedekindPkg.sv
source/botIntake.sv
source/permuteCheck6.sv
source/coeffAccumulate.sv
source/outputBuffer.sv
source/openCLFullPipeline.sv
testbench/openCLFullPipelineTb.sv

/* runSim.sh */
#!/bin/sh
# compile and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1
log=sim.log

rm -rf obj_dir
verilator --binary --timing -f vlog.f --top-module openCLFullPipelineTb -o simTb
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

./obj_dir/simTb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '>>> FAIL' "$log"; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation passed"
exit 0
